//--- compile.f
+incdir+rtl
rtl/sdh_pkg.sv
rtl/sdh_if.sv
rtl/sdh_apb_regs.sv
rtl/sdh_ahb_reader.sv
rtl/sdh_word_fifo.sv
rtl/sdh_dat_tx.sv
rtl/sdh_top.sv
verification/sdh_properties.sv
verification/sdh_checker.sv
verification/sdh_tb.sv

//--- Bender.yml
package:
  name: sdh_host

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/sdh_pkg.sv
      - rtl/sdh_if.sv
      - rtl/sdh_apb_regs.sv
      - rtl/sdh_ahb_reader.sv
      - rtl/sdh_word_fifo.sv
      - rtl/sdh_dat_tx.sv
      - rtl/sdh_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - verification/sdh_properties.sv
      - verification/sdh_checker.sv
      - verification/sdh_tb.sv

//--- verification/sdh_tb.sv
`timescale 1ns/1ps
`include "sdh_defines.svh"

module sdh_tb;

    localparam int NUM_TESTS   = 12;
    localparam int MEM_WORDS   = 256;      // 1 KiB
    localparam int CYCLE_LIMIT = (NUM_TESTS + 3) * (`SDH_MAX_WORDS * 10 * 8 + 2000);

    logic                   clk_i;
    logic                   rst_n_i;
    logic                   psel_i;
    logic                   penable_i;
    logic                   pwrite_i;
    logic [15:0]            paddr_i;
    logic [31:0]            pwdata_i;
    logic [31:0]            prdata_o;
    logic                   pslverr_o;
    logic                   irq_o;
    logic                   hready_i;
    logic                   hresp_i;
    logic [`SDH_DATA_W-1:0] hrdata_i;
    logic [`SDH_ADDR_W-1:0] haddr_o;
    logic [1:0]             htrans_o;
    logic                   sd_clk_o;
    logic [3:0]             sd_dat_o;
    logic                   sd_dat_oe_o;

    logic [31:0] mem [MEM_WORDS];
    logic [31:0] err_addr;
    logic        err_en;
    logic        dp_err;
    int          wait_cnt;
    int          cycles = 0;
    int          frames_exp;
    int          chk_errors;
    int          chk_checks;
    int          frames_seen;
    int          total_err;

    sdh_top sdh_top_inst (.*);

    sdh_checker sdh_checker_inst (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .sd_clk_i    (sd_clk_o),
        .sd_dat_i    (sd_dat_o),
        .sd_dat_oe_i (sd_dat_oe_o),
        .err_cnt_o   (chk_errors),
        .check_cnt_o (chk_checks),
        .frame_cnt_o (frames_seen)
    );

    bind sdh_top sdh_properties sdh_properties_inst (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .hready_i (hready_i),
        .haddr_i  (haddr_o),
        .htrans_i (htrans_o),
        .sd_clk_i (sd_clk_o),
        .sd_dat_i (sd_dat_o),
        .busy_i   (sdh_apb_regs_inst.busy)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run went past %0d cycles without finishing", CYCLE_LIMIT);
            $display("Some tests failed");
            $finish;
        end
    end

    // AHB memory, 0 to 3 wait states, two cycle error response
    always @(posedge clk_i) begin
        int   waits;
        logic hit;
        if (!rst_n_i) begin
            hready_i <= 1'b1;
            hresp_i  <= 1'b0;
            wait_cnt <= 0;
        end else if (hready_i) begin
            hresp_i <= 1'b0;
            if (htrans_o == 2'b10) begin
                hit      = err_en && (haddr_o == err_addr);
                waits    = $urandom_range(3, 0) + int'(hit);
                dp_err   <= hit;
                wait_cnt <= waits;
                hrdata_i <= mem[haddr_o[9:2]];
                if (waits > 0) begin
                    hready_i <= 1'b0;
                    hresp_i  <= hit && waits == 1;
                end
            end
        end else begin
            wait_cnt <= wait_cnt - 1;
            if (wait_cnt == 1) begin
                hready_i <= 1'b1;
                hresp_i  <= dp_err;
            end else if (wait_cnt == 2) begin
                hresp_i  <= dp_err;
            end
        end
    end

    task automatic apb_access(input logic wr, input logic [15:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic slverr);
        @(posedge clk_i);
        psel_i    <= 1'b1;
        pwrite_i  <= wr;
        paddr_i   <= addr;
        pwdata_i  <= wdata;
        @(posedge clk_i);
        penable_i <= 1'b1;
        @(negedge clk_i);                       // Middle of the enable cycle
        rdata     = prdata_o;
        slverr    = pslverr_o;
        @(posedge clk_i);
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
        pwrite_i  <= 1'b0;
    endtask

    task automatic reg_write(input logic [15:0] addr, input logic [31:0] wdata);
        logic [31:0] rd;
        logic        se;
        apb_access(1'b1, addr, wdata, rd, se);
        sdh_checker_inst.compare("pslverr_o", 32'h0, {31'h0, se});
    endtask

    task automatic expect_reg(input logic [15:0] addr, input string name, input logic [31:0] exp);
        logic [31:0] rd;
        logic        se;
        apb_access(1'b0, addr, 32'h0, rd, se);
        sdh_checker_inst.compare(name, exp, rd);
    endtask

    task automatic run_block(input int base, input int count, input int div, input bit aborts);
        logic [31:0] st;
        logic        se;
        for (int i = 0; i < count; i++) sdh_checker_inst.load_word(i, mem[base + i]);
        sdh_checker_inst.arm(count, div, aborts);
        reg_write(sdh_pkg::REG_ADDR, base * 4);
        reg_write(sdh_pkg::REG_COUNT, count);
        reg_write(sdh_pkg::REG_CTRL, {16'h0, 8'(div), 8'h01});
        apb_access(1'b0, sdh_pkg::REG_STATUS, 32'h0, st, se);
        sdh_checker_inst.compare("STATUS.busy", 32'h1, {31'h0, st[0]});
        while (!st[1]) apb_access(1'b0, sdh_pkg::REG_STATUS, 32'h0, st, se);
        sdh_checker_inst.compare("STATUS", aborts ? 32'h6 : 32'h2, st);
        sdh_checker_inst.compare("irq_o", 32'h1, {31'h0, irq_o});
        reg_write(sdh_pkg::REG_STATUS, 32'h6);  // Clear done and err
        expect_reg(sdh_pkg::REG_STATUS, "STATUS", 32'h0);
        sdh_checker_inst.compare("irq_o", 32'h0, {31'h0, irq_o});
        frames_exp++;
        sdh_checker_inst.compare("SD frame count", frames_exp, frames_seen);
    endtask

    initial begin
        int unsigned seed;
        int          base;
        int          count;
        int          bad;
        logic [31:0] val;
        logic        se;
        seed       = $urandom(32'h1e9b68f8);
        rst_n_i    = 1'b0;
        psel_i     = 1'b0;
        penable_i  = 1'b0;
        pwrite_i   = 1'b0;
        paddr_i    = '0;
        pwdata_i   = '0;
        hready_i   = 1'b1;
        hresp_i    = 1'b0;
        hrdata_i   = '0;
        err_en     = 1'b0;
        err_addr   = '0;
        frames_exp = 0;
        for (int i = 0; i < MEM_WORDS; i++) mem[i] = $urandom;
        repeat (16) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(posedge clk_i);

        sdh_checker_inst.compare("htrans_o", 32'h0, {30'h0, htrans_o});
        sdh_checker_inst.compare("sd_dat_oe_o", 32'h0, {31'h0, sd_dat_oe_o});
        sdh_checker_inst.compare("sd_clk_o", 32'h0, {31'h0, sd_clk_o});
        sdh_checker_inst.compare("sd_dat_o", 32'hF, {28'h0, sd_dat_o});
        sdh_checker_inst.compare("irq_o", 32'h0, {31'h0, irq_o});
        expect_reg(sdh_pkg::REG_STATUS, "STATUS", 32'h0);

        val = $urandom & 32'hFFFF_FFFC;
        reg_write(sdh_pkg::REG_ADDR, val);
        expect_reg(sdh_pkg::REG_ADDR, "ADDR", val);
        reg_write(sdh_pkg::REG_COUNT, 32'h5A);
        expect_reg(sdh_pkg::REG_COUNT, "COUNT", 32'h5A);
        reg_write(sdh_pkg::REG_CTRL, 32'h0000_0200);   // Divider only, no start
        expect_reg(sdh_pkg::REG_CTRL, "CTRL", 32'h0000_0200);
        apb_access(1'b0, 16'h0010, 32'h0, val, se);
        sdh_checker_inst.compare("pslverr_o", 32'h1, {31'h0, se});

        for (int t = 0; t < NUM_TESTS; t++) begin
            count = $urandom_range(`SDH_MAX_WORDS, 1);
            base  = $urandom_range(MEM_WORDS - count, 0);
            run_block(base, count, $urandom_range(3, 0), 1'b0);
        end

        count    = $urandom_range(64, 8);
        base     = $urandom_range(MEM_WORDS - count, 0);
        bad      = $urandom_range(count - 1, 1);
        err_addr <= (base + bad) * 4;
        err_en   <= 1'b1;
        run_block(base, count, $urandom_range(3, 0), 1'b1);
        err_en   <= 1'b0;
        count = $urandom_range(`SDH_MAX_WORDS, 1);
        base  = $urandom_range(MEM_WORDS - count, 0);
        run_block(base, count, $urandom_range(3, 0), 1'b0);

        repeat (4) @(posedge clk_i);
        total_err = chk_errors + sdh_top_inst.sdh_properties_inst.fail_cnt;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d", chk_checks, chk_errors,
                 sdh_top_inst.sdh_properties_inst.fail_cnt);
        if (total_err == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- verification/sdh_checker.sv
`timescale 1ns/1ps
`include "sdh_defines.svh"

module sdh_checker (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       sd_clk_i,
    input  logic [3:0] sd_dat_i,
    input  logic       sd_dat_oe_i,
    output int         err_cnt_o,
    output int         check_cnt_o,
    output int         frame_cnt_o
);

    logic [`SDH_DATA_W-1:0] words [`SDH_MAX_WORDS];
    logic [3:0][15:0]       crc;            // Expected CRC per line
    int                     n_words;
    int                     div;
    bit                     abort_exp;
    int                     pos;            // Nibbles seen in this frame
    int                     gap;
    logic                   clk_q;
    logic                   oe_q;

    initial begin
        err_cnt_o   = 0;
        check_cnt_o = 0;
        frame_cnt_o = 0;
        pos         = 0;
    end

    function automatic logic [15:0] crc_next(input logic [15:0] c, input logic b);
        logic [15:0] r;
        r = c << 1;
        if (c[15] != b) r = r ^ `SDH_CRC_POLY;
        return r;
    endfunction

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        check_cnt_o++;
        if (exp !== act) begin
            err_cnt_o++;
            $display("Error at %0t ns: %s expected 0x%0h, actual 0x%0h", $time, name, exp, act);
        end
    endtask

    task automatic report_failure(input string what);
        err_cnt_o++;
        $display("Failure at %0t ns: %s", $time, what);
    endtask

    task automatic load_word(input int idx, input logic [31:0] w);
        words[idx] = w;
    endtask

    task automatic arm(input int count, input int clk_div, input bit aborts);
        n_words   = count;
        div       = clk_div;
        abort_exp = aborts;
        pos       = 0;
        crc       = '0;
    endtask

    task automatic take_nibble(input logic [3:0] d);
        logic [3:0] exp;
        int         k;
        int         w;
        int         n;
        k = pos - 1 - 8 * n_words;              // Index into the CRC bits
        if (pos == 0) begin
            exp = 4'h0;                         // Start bit
        end else if (k < 0) begin
            w   = (pos - 1) / 8;
            n   = (pos - 1) % 8;
            exp = words[w][31 - 4 * n -: 4];
            for (int l = 0; l < 4; l++) crc[l] = crc_next(crc[l], exp[l]);
        end else if (k < 16) begin
            for (int l = 0; l < 4; l++) exp[l] = crc[l][15 - k];
        end else begin
            exp = 4'hF;
        end
        if (k > 16) report_failure("data lines still driven after the end bit");
        compare("sd_dat_o", 32'(exp), 32'(d));
        pos++;
    endtask

    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            clk_q = 1'b0;
            oe_q  = 1'b0;
            gap   = 0;
        end else begin
            gap++;
            if (sd_clk_i && !clk_q && sd_dat_oe_i) begin
                if (pos > 0 && gap < 2 * (div + 1))
                    report_failure($sformatf("SD clock rose %0d cycles after the last edge", gap));
                gap = 0;
                take_nibble(sd_dat_i);
            end
            if (oe_q && !sd_dat_oe_i) begin
                frame_cnt_o++;
                if (abort_exp && pos >= 8 * n_words + 18)
                    report_failure("end bit sent on an aborted block");
                else if (!abort_exp && pos != 8 * n_words + 18)
                    report_failure($sformatf("frame of %0d nibbles, %0d expected",
                                             pos, 8 * n_words + 18));
            end
            clk_q = sd_clk_i;
            oe_q  = sd_dat_oe_i;
        end
    end

endmodule

//--- verification/sdh_properties.sv
`timescale 1ns/1ps
`include "sdh_defines.svh"

module sdh_properties (
    input logic                   clk_i,
    input logic                   rst_n_i,
    input logic                   hready_i,
    input logic [`SDH_ADDR_W-1:0] haddr_i,
    input logic [1:0]             htrans_i,
    input logic                   sd_clk_i,
    input logic [3:0]             sd_dat_i,
    input logic                   busy_i
);

    int fail_cnt = 0;

    // Address phase frozen through wait states
    ahb_hold_in_wait: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !hready_i |=> $stable(haddr_i) && $stable(htrans_i))
        else begin
            fail_cnt++;
            $error("haddr_o or htrans_o moved while hready_i was low");
        end

    sd_dat_on_low_clk: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $changed(sd_dat_i) |-> !sd_clk_i)
        else begin
            fail_cnt++;
            $error("sd_dat_o changed while sd_clk_o was high");
        end

    ahb_idle_when_free: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !busy_i |-> htrans_i == 2'b00)
        else begin
            fail_cnt++;
            $error("htrans_o active while the block is not busy");
        end

endmodule

//--- rtl/sdh_top.sv
`timescale 1ns/1ps
`include "sdh_defines.svh"

module sdh_top (
    input  logic                   clk_i,
    input  logic                   rst_n_i,

    // APB slave
    input  logic                   psel_i,
    input  logic                   penable_i,
    input  logic                   pwrite_i,
    input  logic [15:0]            paddr_i,
    input  logic [31:0]            pwdata_i,
    output logic [31:0]            prdata_o,
    output logic                   pslverr_o,
    output logic                   irq_o,

    // AHB master, read only
    input  logic                   hready_i,
    input  logic                   hresp_i,
    input  logic [`SDH_DATA_W-1:0] hrdata_i,
    output logic [`SDH_ADDR_W-1:0] haddr_o,
    output logic [1:0]             htrans_o,

    // SD card data lines
    output logic                   sd_clk_o,
    output logic [3:0]             sd_dat_o,
    output logic                   sd_dat_oe_o
);

    sdh_cfg_if  cfg_if ();
    sdh_word_if word_if ();

    sdh_apb_regs sdh_apb_regs_inst (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pslverr_o (pslverr_o),
        .irq_o     (irq_o),
        .cfg       (cfg_if)
    );

    sdh_ahb_reader sdh_ahb_reader_inst (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .hready_i (hready_i),
        .hresp_i  (hresp_i),
        .hrdata_i (hrdata_i),
        .haddr_o  (haddr_o),
        .htrans_o (htrans_o),
        .cfg      (cfg_if),
        .wq       (word_if)
    );

    sdh_word_fifo sdh_word_fifo_inst (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (cfg_if.abort),   // Drop words of an aborted block
        .wr      (word_if)
    );

    sdh_dat_tx sdh_dat_tx_inst (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .sd_clk_o    (sd_clk_o),
        .sd_dat_o    (sd_dat_o),
        .sd_dat_oe_o (sd_dat_oe_o),
        .cfg         (cfg_if),
        .rq          (word_if)
    );

endmodule

//--- rtl/sdh_dat_tx.sv
`timescale 1ns/1ps
`include "sdh_defines.svh"

module sdh_dat_tx (
    input  logic          clk_i,
    input  logic          rst_n_i,
    output logic          sd_clk_o,
    output logic [3:0]    sd_dat_o,
    output logic          sd_dat_oe_o,
    sdh_cfg_if.tx         cfg,
    sdh_word_if.consumer  rq
);

    sdh_pkg::tx_state_e     state;
    logic [7:0]             div_cnt;
    logic [2:0]             nib_idx;
    logic [3:0]             crc_idx;
    logic [`SDH_CNT_W-1:0]  word_cnt;   // Words taken from the FIFO
    logic [`SDH_DATA_W-1:0] word_q;
    logic [3:0][15:0]       crc_q;      // One per data line
    logic                   last_nib;
    logic                   more_words;
    logic                   need_word;
    logic                   stall;
    logic                   fall_evt;
    logic                   send_data;
    logic                   send_crc;
    logic [3:0]             data_nib;
    logic [3:0]             crc_msb;

    function automatic logic [15:0] crc16_step(input logic [15:0] crc, input logic din);
        logic fb;
        fb = crc[15] ^ din;
        return {crc[14:0], 1'b0} ^ (fb ? `SDH_CRC_POLY : 16'h0000);
    endfunction

    assign last_nib   = (nib_idx == 3'd7);
    assign more_words = (word_cnt != cfg.word_count);
    assign need_word  = (state == sdh_pkg::TX_START)
                     || (state == sdh_pkg::TX_DATA && last_nib && more_words);
    // Hold the clock low before the rising edge until the next word is there
    assign stall      = !sd_clk_o && need_word && rq.empty;
    assign fall_evt   = sd_clk_o && (div_cnt == cfg.clk_div);
    assign send_data  = fall_evt && ((state == sdh_pkg::TX_START)
                     || (state == sdh_pkg::TX_DATA && (!last_nib || more_words)));
    assign send_crc   = fall_evt && ((state == sdh_pkg::TX_DATA && last_nib && !more_words)
                     || (state == sdh_pkg::TX_CRC && crc_idx != 4'd15));
    assign rq.pop     = fall_evt && need_word;
    assign data_nib   = rq.pop ? rq.rdata[31:28] : word_q[31:28];
    assign crc_msb    = {crc_q[3][15], crc_q[2][15], crc_q[1][15], crc_q[0][15]};

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || cfg.abort || state == sdh_pkg::TX_IDLE) begin
            div_cnt  <= '0;
            sd_clk_o <= 1'b0;
        end else if (!stall) begin
            if (div_cnt == cfg.clk_div) begin
                div_cnt  <= '0;
                sd_clk_o <= !sd_clk_o;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (cfg.start) crc_q <= '0;
        else if (send_data) for (int l = 0; l < 4; l++) crc_q[l] <= crc16_step(crc_q[l], data_nib[l]);
        else if (send_crc) for (int l = 0; l < 4; l++) crc_q[l] <= {crc_q[l][14:0], 1'b0};
        if (rq.pop) word_q <= {rq.rdata[27:0], 4'h0};
        else if (send_data) word_q <= {word_q[27:0], 4'h0};
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || cfg.abort) begin
            state       <= sdh_pkg::TX_IDLE;
            nib_idx     <= '0;
            crc_idx     <= '0;
            word_cnt    <= '0;
            sd_dat_o    <= 4'hF;
            sd_dat_oe_o <= 1'b0;
            cfg.tx_done <= 1'b0;
        end else begin
            cfg.tx_done <= 1'b0;
            case (state)
                sdh_pkg::TX_IDLE: if (cfg.start) begin
                    state       <= sdh_pkg::TX_START;
                    word_cnt    <= '0;
                    sd_dat_o    <= 4'h0;            // Start bit on every line
                    sd_dat_oe_o <= 1'b1;
                end
                sdh_pkg::TX_START: if (fall_evt) begin
                    state    <= sdh_pkg::TX_DATA;
                    nib_idx  <= '0;
                    word_cnt <= word_cnt + 1'b1;
                    sd_dat_o <= data_nib;
                end
                sdh_pkg::TX_DATA: if (fall_evt) begin
                    if (!last_nib) begin
                        nib_idx  <= nib_idx + 1'b1;
                        sd_dat_o <= data_nib;
                    end else if (more_words) begin
                        nib_idx  <= '0;
                        word_cnt <= word_cnt + 1'b1;
                        sd_dat_o <= data_nib;
                    end else begin
                        state    <= sdh_pkg::TX_CRC;
                        crc_idx  <= '0;
                        sd_dat_o <= crc_msb;
                    end
                end
                sdh_pkg::TX_CRC: if (fall_evt) begin
                    if (crc_idx != 4'd15) begin
                        crc_idx  <= crc_idx + 1'b1;
                        sd_dat_o <= crc_msb;
                    end else begin
                        state    <= sdh_pkg::TX_END;
                        sd_dat_o <= 4'hF;
                    end
                end
                sdh_pkg::TX_END: if (fall_evt) begin
                    state       <= sdh_pkg::TX_IDLE;
                    sd_dat_oe_o <= 1'b0;
                    cfg.tx_done <= 1'b1;
                end
                default: state <= sdh_pkg::TX_IDLE;
            endcase
        end
    end

endmodule

//--- rtl/sdh_word_fifo.sv
`timescale 1ns/1ps
`include "sdh_defines.svh"

module sdh_word_fifo (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     flush_i,
    sdh_word_if.fifo wr
);

    localparam int PTR_W = $clog2(`SDH_FIFO_DEPTH);
    localparam int LVL_W = PTR_W + 1;

    logic [`SDH_DATA_W-1:0] mem [`SDH_FIFO_DEPTH];
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;
    logic                   do_push;
    logic                   do_pop;

    assign do_push  = wr.push && (wr.level != LVL_W'(`SDH_FIFO_DEPTH));
    assign do_pop   = wr.pop && !wr.empty;
    assign wr.empty = (wr.level == '0);
    assign wr.rdata = mem[rd_ptr];

    always_ff @(posedge clk_i) begin
        if (do_push) mem[wr_ptr] <= wr.wdata;
    end

    // Pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            wr.level <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            wr.level <= wr.level + LVL_W'(do_push) - LVL_W'(do_pop);
        end
    end

endmodule

//--- rtl/sdh_ahb_reader.sv
`timescale 1ns/1ps
`include "sdh_defines.svh"

module sdh_ahb_reader (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   hready_i,
    input  logic                   hresp_i,
    input  logic [`SDH_DATA_W-1:0] hrdata_i,
    output logic [`SDH_ADDR_W-1:0] haddr_o,
    output logic [1:0]             htrans_o,
    sdh_cfg_if.reader              cfg,
    sdh_word_if.producer           wq
);

    localparam int LVL_W = $clog2(`SDH_FIFO_DEPTH) + 1;
    localparam int CNT_W = `SDH_CNT_W;
    localparam logic [1:0] HTRANS_IDLE   = 2'b00;
    localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
    localparam logic [`SDH_ADDR_W-1:0] WORD_STEP = 4;
    localparam logic [LVL_W:0] DEPTH = `SDH_FIFO_DEPTH;

    sdh_pkg::rd_state_e state;
    logic [CNT_W-1:0]   req_cnt;     // Address phases issued
    logic               dphase;      // A read sits in its data phase
    logic               addr_ph;
    logic [LVL_W:0]     committed;
    logic               more_req;
    logic               issue;
    logic               ahb_err;

    assign addr_ph   = (htrans_o == HTRANS_NONSEQ);
    // Words already in the FIFO plus reads still in the pipe
    assign committed = {1'b0, wq.level} + {{LVL_W{1'b0}}, dphase}
                     + {{LVL_W{1'b0}}, addr_ph};
    assign more_req  = (req_cnt != cfg.word_count);
    assign issue     = more_req && (committed < DEPTH);
    assign ahb_err   = dphase && hready_i && hresp_i;

    assign wq.push  = (state == sdh_pkg::RD_RUN) && dphase && hready_i && !hresp_i;
    assign wq.wdata = hrdata_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state     <= sdh_pkg::RD_IDLE;
            haddr_o   <= '0;
            htrans_o  <= HTRANS_IDLE;
            req_cnt   <= '0;
            dphase    <= 1'b0;
            cfg.abort <= 1'b0;
        end else begin
            cfg.abort <= 1'b0;
            case (state)
                sdh_pkg::RD_IDLE: if (cfg.start) begin
                    state    <= sdh_pkg::RD_RUN;
                    haddr_o  <= cfg.base_addr;
                    htrans_o <= HTRANS_NONSEQ;
                    req_cnt  <= CNT_W'(1);
                end
                sdh_pkg::RD_RUN: if (hready_i) begin  // Hold everything in wait states
                    dphase <= addr_ph;
                    if (ahb_err) begin
                        state     <= sdh_pkg::RD_DRAIN;
                        htrans_o  <= HTRANS_IDLE;
                        cfg.abort <= 1'b1;
                    end else if (issue) begin
                        haddr_o  <= haddr_o + WORD_STEP;
                        htrans_o <= HTRANS_NONSEQ;
                        req_cnt  <= req_cnt + 1'b1;
                    end else begin
                        htrans_o <= HTRANS_IDLE;   // Done or no FIFO room
                        if (!more_req && !addr_ph) state <= sdh_pkg::RD_IDLE;
                    end
                end
                sdh_pkg::RD_DRAIN: if (hready_i) begin
                    // Read accepted with the error response finishes here, dropped
                    dphase <= 1'b0;
                    state  <= sdh_pkg::RD_IDLE;
                end
                default: state <= sdh_pkg::RD_IDLE;
            endcase
        end
    end

endmodule

//--- rtl/sdh_apb_regs.sv
`timescale 1ns/1ps
`include "sdh_defines.svh"

module sdh_apb_regs (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        psel_i,
    input  logic        penable_i,
    input  logic        pwrite_i,
    input  logic [15:0] paddr_i,
    input  logic [31:0] pwdata_i,
    output logic [31:0] prdata_o,
    output logic        pslverr_o,
    output logic        irq_o,
    sdh_cfg_if.regs     cfg
);

    logic busy;
    logic done;
    logic err;
    logic mapped;
    logic wr_en;

    always_comb begin
        mapped   = 1'b1;
        prdata_o = '0;
        case (paddr_i)
            sdh_pkg::REG_CTRL:   prdata_o = {16'h0000, cfg.clk_div, 8'h00};
            sdh_pkg::REG_ADDR:   prdata_o = cfg.base_addr;
            sdh_pkg::REG_COUNT:  prdata_o = {{(32-`SDH_CNT_W){1'b0}}, cfg.word_count};
            sdh_pkg::REG_STATUS: prdata_o = {29'h0, err, done, busy};
            default:             mapped = 1'b0;
        endcase
    end

    assign pslverr_o = psel_i && penable_i && !mapped;
    assign wr_en     = psel_i && penable_i && pwrite_i && mapped;
    assign irq_o     = done;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            cfg.start      <= 1'b0;
            cfg.base_addr  <= '0;
            cfg.word_count <= '0;
            cfg.clk_div    <= '0;
            busy           <= 1'b0;
            done           <= 1'b0;
            err            <= 1'b0;
        end else begin
            cfg.start <= 1'b0;
            if (wr_en) begin
                case (paddr_i)
                    // Setup is frozen while a block is in flight
                    sdh_pkg::REG_CTRL: if (!busy) begin
                        cfg.clk_div <= pwdata_i[15:8];
                        if (pwdata_i[0] && cfg.word_count != '0) begin
                            cfg.start <= 1'b1;
                            busy      <= 1'b1;
                        end
                    end
                    sdh_pkg::REG_ADDR: if (!busy) begin
                        cfg.base_addr <= {pwdata_i[`SDH_ADDR_W-1:2], 2'b00};
                    end
                    sdh_pkg::REG_COUNT: if (!busy) begin
                        cfg.word_count <= pwdata_i[`SDH_CNT_W-1:0];
                    end
                    sdh_pkg::REG_STATUS: begin
                        if (pwdata_i[1]) done <= 1'b0;   // W1C
                        if (pwdata_i[2]) err  <= 1'b0;
                    end
                    default: ;
                endcase
            end
            if (cfg.tx_done) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
            if (cfg.abort) begin
                busy <= 1'b0;
                done <= 1'b1;
                err  <= 1'b1;
            end
        end
    end

endmodule

//--- rtl/sdh_if.sv
`timescale 1ns/1ps
`include "sdh_defines.svh"

interface sdh_cfg_if;
    logic                   start;      // One cycle pulse
    logic [`SDH_ADDR_W-1:0] base_addr;
    logic [`SDH_CNT_W-1:0]  word_count;
    logic [7:0]             clk_div;
    logic                   abort;      // AHB error seen by the reader
    logic                   tx_done;

    modport regs   (output start, base_addr, word_count, clk_div,
                    input  abort, tx_done);
    modport reader (input  start, base_addr, word_count,
                    output abort);
    modport tx     (input  start, word_count, clk_div, abort,
                    output tx_done);
endinterface

interface sdh_word_if;
    logic                                push;
    logic [`SDH_DATA_W-1:0]              wdata;
    logic                                pop;
    logic [`SDH_DATA_W-1:0]              rdata;   // Head of queue
    logic                                empty;
    logic [$clog2(`SDH_FIFO_DEPTH):0]    level;

    modport producer (output push, wdata, input level);
    modport fifo     (input  push, wdata, pop,
                      output rdata, empty, level);
    modport consumer (output pop, input rdata, empty);
endinterface

//--- rtl/sdh_pkg.sv
package sdh_pkg;

    // APB register map
    typedef enum logic [15:0] {
        REG_CTRL   = 16'h0000,  // Start in bit 0, divider in 15:8
        REG_ADDR   = 16'h0004,
        REG_COUNT  = 16'h0008,
        REG_STATUS = 16'h000C   // Busy, done and err in bits 2:0
    } sdh_reg_e;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_RUN,
        RD_DRAIN
    } rd_state_e;

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_CRC,
        TX_END
    } tx_state_e;

endpackage

//--- rtl/sdh_defines.svh
`ifndef SDH_DEFINES_SVH
`define SDH_DEFINES_SVH

// Bus widths
`define SDH_ADDR_W      32
`define SDH_DATA_W      32

`define SDH_FIFO_DEPTH  8
`define SDH_MAX_WORDS   128   // 512 bytes per block
`define SDH_CNT_W       8

// CRC16-CCITT, register starts at zero
`define SDH_CRC_POLY    16'h1021

`endif
